/* src/tlx_cmd_pkg.sv */
// ----------------------------------------
// shared TLX command definitions
// field widths, command struct, credit reserves
// and write opcode decode
// ----------------------------------------
package tlx_cmd_pkg;

  // TLX command field widths
  localparam int OPCODE_W = 8;
  localparam int EA_W     = 68;
  localparam int AFUTAG_W = 16;
  localparam int DL_W     = 2;
  localparam int PL_W     = 3;
  localparam int ACTAG_W  = 12;
  localparam int PASID_W  = 20;

  // credit counter widths
  localparam int CMD_CREDIT_W  = 4;
  localparam int DATA_CREDIT_W = 6;

  // issue needs cmd credit above, data credit at or above these
  localparam logic [CMD_CREDIT_W-1:0]  CMD_CREDIT_RESERVE  = 4'd3;
  localparam logic [DATA_CREDIT_W-1:0] DATA_CREDIT_RESERVE = 6'd5;

  // one overflow flag per FIFO
  localparam int FIFO_COUNT = 4;

  // TLX opcodes
  localparam logic [OPCODE_W-1:0] OPC_RD_WNITC  = 8'h10;
  localparam logic [OPCODE_W-1:0] OPC_DMA_W     = 8'h20;
  localparam logic [OPCODE_W-1:0] OPC_DMA_W_N   = 8'h24;
  localparam logic [OPCODE_W-1:0] OPC_DMA_PR_W  = 8'h30;
  localparam logic [OPCODE_W-1:0] OPC_INTRP_REQ = 8'h58;

  // opcode in the low byte, pasid on top, 129 bits
  typedef struct packed {
    logic [PASID_W-1:0]  pasid;
    logic [ACTAG_W-1:0]  actag;
    logic [PL_W-1:0]     pl;
    logic [DL_W-1:0]     dl;
    logic [AFUTAG_W-1:0] afutag;
    logic [EA_W-1:0]     ea_or_obj;
    logic [OPCODE_W-1:0] opcode;
  } tlx_cmd_t;

  // commands that carry write data
  function automatic logic is_write_op(input logic [OPCODE_W-1:0] opcode);
    return (opcode == OPC_DMA_W) || (opcode == OPC_DMA_W_N) || (opcode == OPC_DMA_PR_W);
  endfunction

endpackage

/* src/cmd_fifo.sv */
// ----------------------------------------
// synchronous FIFO, first word through
// fill count, full/empty, sticky overflow
// ----------------------------------------
`timescale 1ns/1ps

module cmd_fifo #(
  parameter int WIDTH      = 129,
  parameter int FIFO_DEPTH = 16
) (
  input  logic                        clock_tlx,
  input  logic                        resetn,
  input  logic [WIDTH-1:0]            din,
  input  logic                        push,
  input  logic                        pop,
  output logic [WIDTH-1:0]            dout,
  output logic                        empty,
  output logic                        full,
  output logic [$clog2(FIFO_DEPTH):0] count,
  output logic                        overflow
);

  localparam int AW = $clog2(FIFO_DEPTH);

  logic [WIDTH-1:0] mem [FIFO_DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic             wr_en;
  logic             rd_en;

  assign empty = (count == '0);
  assign full  = (count == (AW+1)'(FIFO_DEPTH));
  // a push into a full FIFO is lost
  assign wr_en = push && !full;
  assign rd_en = pop && !empty;
  // head entry shows without a read cycle
  assign dout  = mem[rd_ptr];

  always_ff @(posedge clock_tlx)
  begin
    if (wr_en)
      mem[wr_ptr] <= din;
  end

  always_ff @(posedge clock_tlx or negedge resetn)
  begin
    if (!resetn)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + AW'(1);
      if (rd_en)
        rd_ptr <= rd_ptr + AW'(1);
      case ({wr_en, rd_en})
        2'b10:   count <= count + (AW+1)'(1);
        2'b01:   count <= count - (AW+1)'(1);
        default: count <= count;
      endcase
      // stays set until reset
      if (push && full)
        overflow <= 1'b1;
    end
  end

endmodule

/* src/credit_tracker.sv */
// ----------------------------------------
// TLX command and data credit counters
// and the issue permission level
// ----------------------------------------
`timescale 1ns/1ps

module credit_tracker (
  input  logic                                  clock_tlx,
  input  logic                                  resetn,
  input  logic                                  tlx_afu_cmd_credit,
  input  logic                                  tlx_afu_cmd_data_credit,
  input  logic [tlx_cmd_pkg::CMD_CREDIT_W-1:0]  tlx_afu_cmd_initial_credit,
  input  logic [tlx_cmd_pkg::DATA_CREDIT_W-1:0] tlx_afu_cmd_data_initial_credit,
  input  logic                                  afu_tlx_cmd_valid,
  input  logic                                  afu_tlx_cdata_valid,
  output logic                                  issue_ok
);

  localparam int CW = tlx_cmd_pkg::CMD_CREDIT_W;
  localparam int DW = tlx_cmd_pkg::DATA_CREDIT_W;

  logic [CW-1:0] cmd_credit_cnt;
  logic [DW-1:0] data_credit_cnt;

  // initial credits load for as long as reset is held
  always_ff @(posedge clock_tlx or negedge resetn)
  begin
    if (!resetn)
      cmd_credit_cnt <= tlx_afu_cmd_initial_credit;
    else
    begin
      case ({tlx_afu_cmd_credit, afu_tlx_cmd_valid})
        2'b10:   cmd_credit_cnt <= cmd_credit_cnt + CW'(1);
        2'b01:   cmd_credit_cnt <= cmd_credit_cnt - CW'(1);
        default: cmd_credit_cnt <= cmd_credit_cnt;
      endcase
    end
  end

  // one data credit per beat
  always_ff @(posedge clock_tlx or negedge resetn)
  begin
    if (!resetn)
      data_credit_cnt <= tlx_afu_cmd_data_initial_credit;
    else
    begin
      case ({tlx_afu_cmd_data_credit, afu_tlx_cdata_valid})
        2'b10:   data_credit_cnt <= data_credit_cnt + DW'(1);
        2'b01:   data_credit_cnt <= data_credit_cnt - DW'(1);
        default: data_credit_cnt <= data_credit_cnt;
      endcase
    end
  end

  assign issue_ok = (cmd_credit_cnt > tlx_cmd_pkg::CMD_CREDIT_RESERVE)
                    && (data_credit_cnt >= tlx_cmd_pkg::DATA_CREDIT_RESERVE);

endmodule

/* src/wdata_sequencer.sv */
// ----------------------------------------
// write data sequencer: even then odd half
// onto the TLX data bus
// ----------------------------------------
`timescale 1ns/1ps

module wdata_sequencer #(
  parameter int HALF_W = 512
) (
  input  logic                  clock_tlx,
  input  logic                  resetn,
  input  logic                  afu_tlx_cmd_valid,
  input  tlx_cmd_pkg::tlx_cmd_t afu_tlx_cmd,
  input  logic [HALF_W-1:0]     even_data,
  input  logic [HALF_W-1:0]     odd_data,
  output logic                  even_pop,
  output logic                  odd_pop,
  output logic                  afu_tlx_cdata_valid,
  output logic [HALF_W-1:0]     afu_tlx_cdata_bus
);

  logic odd_beat;

  // even half goes out with the write command itself
  assign even_pop = afu_tlx_cmd_valid && tlx_cmd_pkg::is_write_op(afu_tlx_cmd.opcode);

  // --------------------------------------
  // odd half, one cycle later
  // --------------------------------------
  // odd FIFO is always drained to stay in step with even
  // the beat only shows when dl bit 1 asks for it
  always_ff @(posedge clock_tlx or negedge resetn)
  begin
    if (!resetn)
    begin
      odd_pop  <= 1'b0;
      odd_beat <= 1'b0;
    end
    else
    begin
      odd_pop  <= even_pop;
      odd_beat <= even_pop && afu_tlx_cmd.dl[1];
    end
  end

  assign afu_tlx_cdata_valid = even_pop || odd_beat;
  // even first
  assign afu_tlx_cdata_bus   = even_pop ? even_data : odd_data;

endmodule

/* src/cmd_arbiter.sv */
// ----------------------------------------
// command arbiter: interrupt hold, write/read
// alternation, credit-gated issue, output register
// ----------------------------------------
`timescale 1ns/1ps

module cmd_arbiter (
  input  logic                  clock_tlx,
  input  logic                  resetn,
  input  tlx_cmd_pkg::tlx_cmd_t wr_head,
  input  tlx_cmd_pkg::tlx_cmd_t rd_head,
  input  logic                  wr_empty,
  input  logic                  rd_empty,
  input  logic                  in_cmd_valid,
  input  tlx_cmd_pkg::tlx_cmd_t in_cmd,
  input  logic                  issue_ok,
  output logic                  wr_pop,
  output logic                  rd_pop,
  output logic                  afu_tlx_cmd_valid,
  output tlx_cmd_pkg::tlx_cmd_t afu_tlx_cmd
);

  logic                  int_pending;
  tlx_cmd_pkg::tlx_cmd_t int_cmd;
  logic                  int_pop;
  logic                  wr_turn;
  logic                  out_two_beat;
  logic                  odd_stall;
  logic                  stall;
  logic                  can_issue;
  tlx_cmd_pkg::tlx_cmd_t next_cmd;

  // --------------------------------------
  // issue gate
  // --------------------------------------
  // credit counters lag the port by a cycle, so hold issue while a
  // command is on the port and during the odd beat of a two-beat write
  assign out_two_beat = afu_tlx_cmd_valid && afu_tlx_cmd.dl[1]
                        && tlx_cmd_pkg::is_write_op(afu_tlx_cmd.opcode);
  assign stall        = afu_tlx_cmd_valid || odd_stall;
  assign can_issue    = issue_ok && !stall;

  // interrupt first, then the channel whose turn it is
  assign int_pop  = can_issue && int_pending;
  assign wr_pop   = can_issue && !int_pending && !wr_empty && (wr_turn || rd_empty);
  assign rd_pop   = can_issue && !int_pending && !rd_empty && (!wr_turn || wr_empty);
  assign next_cmd = int_pending ? int_cmd : (wr_pop ? wr_head : rd_head);

  // interrupt payload
  always_ff @(posedge clock_tlx)
  begin
    if (in_cmd_valid)
      int_cmd <= in_cmd;
  end

  always_ff @(posedge clock_tlx or negedge resetn)
  begin
    if (!resetn)
    begin
      int_pending       <= 1'b0;
      wr_turn           <= 1'b1;
      odd_stall         <= 1'b0;
      afu_tlx_cmd_valid <= 1'b0;
    end
    else
    begin
      if (in_cmd_valid)
        int_pending <= 1'b1;
      else if (int_pop)
        int_pending <= 1'b0;
      // hand the turn to the other channel
      if (wr_pop || rd_pop)
        wr_turn <= !wr_pop;
      odd_stall         <= out_two_beat;
      afu_tlx_cmd_valid <= int_pop || wr_pop || rd_pop;
    end
  end

  // command payload to TLX
  always_ff @(posedge clock_tlx)
  begin
    if (int_pop || wr_pop || rd_pop)
      afu_tlx_cmd <= next_cmd;
  end

endmodule

/* src/tlx_cmd_converter.sv */
// ----------------------------------------
// TLX command converter top level
// command/data FIFOs, arbiter, data sequencer,
// credit tracker, bdf and overflow status
// ----------------------------------------
`timescale 1ns/1ps

module tlx_cmd_converter #(
  parameter int HALF_W     = 512,
  parameter int FIFO_DEPTH = 16
) (
  input  logic                                  clock_tlx,
  input  logic                                  resetn,
  input  logic [7:0]                            cfg_bdf_bus,
  input  logic [4:0]                            cfg_bdf_device,
  input  logic [2:0]                            cfg_bdf_function,
  // write channel, odd half above even
  input  logic                                  wr_cmd_valid,
  input  tlx_cmd_pkg::tlx_cmd_t                 wr_cmd,
  input  logic [2*HALF_W-1:0]                   wr_cdata,
  output logic                                  wr_cmd_ready,
  // read channel
  input  logic                                  rd_cmd_valid,
  input  tlx_cmd_pkg::tlx_cmd_t                 rd_cmd,
  output logic                                  rd_cmd_ready,
  // interrupt channel
  input  logic                                  in_cmd_valid,
  input  tlx_cmd_pkg::tlx_cmd_t                 in_cmd,
  // TLX command and data
  output logic                                  afu_tlx_cmd_valid,
  output tlx_cmd_pkg::tlx_cmd_t                 afu_tlx_cmd,
  output logic [15:0]                           afu_tlx_cmd_bdf,
  output logic                                  afu_tlx_cdata_valid,
  output logic [HALF_W-1:0]                     afu_tlx_cdata_bus,
  // TLX credits
  input  logic                                  tlx_afu_cmd_credit,
  input  logic                                  tlx_afu_cmd_data_credit,
  input  logic [tlx_cmd_pkg::CMD_CREDIT_W-1:0]  tlx_afu_cmd_initial_credit,
  input  logic [tlx_cmd_pkg::DATA_CREDIT_W-1:0] tlx_afu_cmd_data_initial_credit,
  output logic [tlx_cmd_pkg::FIFO_COUNT-1:0]    fir_fifo_overflow
);

  localparam int CMD_W = $bits(tlx_cmd_pkg::tlx_cmd_t);
  localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

  tlx_cmd_pkg::tlx_cmd_t wr_head;
  tlx_cmd_pkg::tlx_cmd_t rd_head;
  logic                  wr_empty;
  logic                  rd_empty;
  logic                  wr_pop;
  logic                  rd_pop;
  logic [CNT_W-1:0]      wr_count;
  logic [CNT_W-1:0]      rd_count;
  logic [HALF_W-1:0]     even_data;
  logic [HALF_W-1:0]     odd_data;
  logic                  even_pop;
  logic                  odd_pop;
  logic                  issue_ok;
  logic                  wr_ovf;
  logic                  rd_ovf;
  logic                  even_ovf;
  logic                  odd_ovf;

  // --------------------------------------
  // input FIFOs
  // --------------------------------------
  cmd_fifo #(.WIDTH(CMD_W), .FIFO_DEPTH(FIFO_DEPTH)) u_wr_cmd_fifo (
    .clock_tlx(clock_tlx), .resetn(resetn), .din(wr_cmd), .push(wr_cmd_valid),
    .pop(wr_pop), .dout(wr_head), .empty(wr_empty), .full(), .count(wr_count),
    .overflow(wr_ovf));

  cmd_fifo #(.WIDTH(HALF_W), .FIFO_DEPTH(FIFO_DEPTH)) u_even_fifo (
    .clock_tlx(clock_tlx), .resetn(resetn), .din(wr_cdata[HALF_W-1:0]),
    .push(wr_cmd_valid), .pop(even_pop), .dout(even_data), .empty(), .full(),
    .count(), .overflow(even_ovf));

  cmd_fifo #(.WIDTH(HALF_W), .FIFO_DEPTH(FIFO_DEPTH)) u_odd_fifo (
    .clock_tlx(clock_tlx), .resetn(resetn), .din(wr_cdata[2*HALF_W-1:HALF_W]),
    .push(wr_cmd_valid), .pop(odd_pop), .dout(odd_data), .empty(), .full(),
    .count(), .overflow(odd_ovf));

  cmd_fifo #(.WIDTH(CMD_W), .FIFO_DEPTH(FIFO_DEPTH)) u_rd_cmd_fifo (
    .clock_tlx(clock_tlx), .resetn(resetn), .din(rd_cmd), .push(rd_cmd_valid),
    .pop(rd_pop), .dout(rd_head), .empty(rd_empty), .full(), .count(rd_count),
    .overflow(rd_ovf));

  // back off the source at half full
  assign wr_cmd_ready = (wr_count < CNT_W'(FIFO_DEPTH / 2));
  assign rd_cmd_ready = (rd_count < CNT_W'(FIFO_DEPTH / 2));

  // --------------------------------------
  // issue path
  // --------------------------------------
  cmd_arbiter u_arbiter (
    .clock_tlx(clock_tlx), .resetn(resetn), .wr_head(wr_head), .rd_head(rd_head),
    .wr_empty(wr_empty), .rd_empty(rd_empty), .in_cmd_valid(in_cmd_valid),
    .in_cmd(in_cmd), .issue_ok(issue_ok), .wr_pop(wr_pop), .rd_pop(rd_pop),
    .afu_tlx_cmd_valid(afu_tlx_cmd_valid), .afu_tlx_cmd(afu_tlx_cmd));

  wdata_sequencer #(.HALF_W(HALF_W)) u_wdata_seq (
    .clock_tlx(clock_tlx), .resetn(resetn), .afu_tlx_cmd_valid(afu_tlx_cmd_valid),
    .afu_tlx_cmd(afu_tlx_cmd), .even_data(even_data), .odd_data(odd_data),
    .even_pop(even_pop), .odd_pop(odd_pop), .afu_tlx_cdata_valid(afu_tlx_cdata_valid),
    .afu_tlx_cdata_bus(afu_tlx_cdata_bus));

  credit_tracker u_credit (
    .clock_tlx(clock_tlx), .resetn(resetn), .tlx_afu_cmd_credit(tlx_afu_cmd_credit),
    .tlx_afu_cmd_data_credit(tlx_afu_cmd_data_credit),
    .tlx_afu_cmd_initial_credit(tlx_afu_cmd_initial_credit),
    .tlx_afu_cmd_data_initial_credit(tlx_afu_cmd_data_initial_credit),
    .afu_tlx_cmd_valid(afu_tlx_cmd_valid), .afu_tlx_cdata_valid(afu_tlx_cdata_valid),
    .issue_ok(issue_ok));

  assign afu_tlx_cmd_bdf   = {cfg_bdf_bus, cfg_bdf_device, cfg_bdf_function};
  // read cmd, even data, odd data, write cmd
  assign fir_fifo_overflow = {rd_ovf, even_ovf, odd_ovf, wr_ovf};

endmodule

/* sim/tlx_cmd_asserts.sv */
// ----------------------------------------
// concurrent checks on arbitration and
// write data sequencing, bound into the DUT
// ----------------------------------------
`timescale 1ns/1ps

module tlx_cmd_asserts (
  input logic clock_tlx,
  input logic resetn,
  input logic int_pop,
  input logic wr_pop,
  input logic rd_pop,
  input logic in_cmd_valid,
  input logic int_pending,
  input logic even_pop,
  input logic odd_pop
);

  // only one source may be popped per cycle
  one_pop_source: assert property (@(posedge clock_tlx) disable iff (!resetn)
    $onehot0({int_pop, wr_pop, rd_pop}))
    else $error("more than one pop source in one cycle");

  // odd half follows each even half on its own
  odd_after_even: assert property (@(posedge clock_tlx) disable iff (!resetn)
    even_pop |=> odd_pop && !even_pop)
    else $error("even data pop not followed by a lone odd data pop");

  no_int_while_pending: assert property (@(posedge clock_tlx) disable iff (!resetn)
    in_cmd_valid |-> !int_pending)
    else $error("interrupt raised while another is pending");

endmodule

bind cmd_arbiter tlx_cmd_asserts u_arb_asserts (
  .clock_tlx(clock_tlx), .resetn(resetn), .int_pop(int_pop), .wr_pop(wr_pop),
  .rd_pop(rd_pop), .in_cmd_valid(in_cmd_valid), .int_pending(int_pending),
  .even_pop(1'b0), .odd_pop(1'b0));

bind wdata_sequencer tlx_cmd_asserts u_seq_asserts (
  .clock_tlx(clock_tlx), .resetn(resetn), .int_pop(1'b0), .wr_pop(1'b0),
  .rd_pop(1'b0), .in_cmd_valid(1'b0), .int_pending(1'b0),
  .even_pop(even_pop), .odd_pop(odd_pop));

/* sim/tb_tlx_cmd_converter.sv */
// ----------------------------------------
// testbench for the TLX command converter
// file-driven stimulus, reference queues,
// credit returns, watchdog and summary
// ----------------------------------------
`timescale 1ns/1ps

module tb_tlx_cmd_converter;

  localparam int HALF_W = 32;
  localparam int DEPTH  = 16;
  localparam int LIMIT  = 200;

  logic clock_tlx;
  logic resetn;
  logic wr_cmd_valid;
  logic rd_cmd_valid;
  logic in_cmd_valid;
  logic tlx_afu_cmd_credit;
  logic tlx_afu_cmd_data_credit;
  logic [3:0] init_cmd_credit;
  logic [5:0] init_data_credit;
  logic [2*HALF_W-1:0] wr_cdata;
  tlx_cmd_pkg::tlx_cmd_t wr_cmd;
  tlx_cmd_pkg::tlx_cmd_t rd_cmd;
  tlx_cmd_pkg::tlx_cmd_t in_cmd;
  logic wr_cmd_ready;
  logic rd_cmd_ready;
  logic afu_tlx_cmd_valid;
  tlx_cmd_pkg::tlx_cmd_t afu_tlx_cmd;
  logic [15:0] afu_tlx_cmd_bdf;
  logic afu_tlx_cdata_valid;
  logic [HALF_W-1:0] afu_tlx_cdata_bus;
  logic [3:0] fir_fifo_overflow;

  // reference model
  tlx_cmd_pkg::tlx_cmd_t wr_q[$];
  tlx_cmd_pkg::tlx_cmd_t rd_q[$];
  tlx_cmd_pkg::tlx_cmd_t int_q[$];
  tlx_cmd_pkg::tlx_cmd_t exp_wr;
  logic [HALF_W-1:0] even_q[$];
  logic [HALF_W-1:0] odd_q[$];
  logic [HALF_W-1:0] beat_q[$];
  string records[$];
  string cur_test;
  int n_issued;
  int n_beats;
  int exp_beats;
  int errors;
  int tests_run;
  int tests_failed;
  bit expect_int;
  bit loaded;

  tlx_cmd_converter #(.HALF_W(HALF_W), .FIFO_DEPTH(DEPTH)) DUT (
    .clock_tlx(clock_tlx), .resetn(resetn), .cfg_bdf_bus(8'h12), .cfg_bdf_device(5'h03),
    .cfg_bdf_function(3'h5), .wr_cmd_valid(wr_cmd_valid), .wr_cmd(wr_cmd),
    .wr_cdata(wr_cdata), .wr_cmd_ready(wr_cmd_ready), .rd_cmd_valid(rd_cmd_valid),
    .rd_cmd(rd_cmd), .rd_cmd_ready(rd_cmd_ready), .in_cmd_valid(in_cmd_valid),
    .in_cmd(in_cmd), .afu_tlx_cmd_valid(afu_tlx_cmd_valid), .afu_tlx_cmd(afu_tlx_cmd),
    .afu_tlx_cmd_bdf(afu_tlx_cmd_bdf), .afu_tlx_cdata_valid(afu_tlx_cdata_valid),
    .afu_tlx_cdata_bus(afu_tlx_cdata_bus), .tlx_afu_cmd_credit(tlx_afu_cmd_credit),
    .tlx_afu_cmd_data_credit(tlx_afu_cmd_data_credit),
    .tlx_afu_cmd_initial_credit(init_cmd_credit),
    .tlx_afu_cmd_data_initial_credit(init_data_credit),
    .fir_fifo_overflow(fir_fifo_overflow));

  initial
  begin
    clock_tlx = 1'b0;
    forever #2 clock_tlx = ~clock_tlx;
  end

  task automatic compare_value(input string what, input logic [159:0] expected,
                               input logic [159:0] actual);
    if (expected !== actual)
    begin
      errors++;
      $display("error %s: %s expected %h actual %h", cur_test, what, expected, actual);
    end
  endtask

  // afutag bits 15:12 carry the channel, 1 write, 2 read, 3 interrupt
  function automatic tlx_cmd_pkg::tlx_cmd_t make_cmd(input logic [7:0] opc,
      input logic [3:0] chan, input logic [11:0] tag, input logic [1:0] dl,
      input logic [63:0] ea);
    tlx_cmd_pkg::tlx_cmd_t c;
    c = '0;
    c.opcode    = opc;
    c.ea_or_obj = {4'h0, ea};
    c.afutag    = {chan, tag};
    c.dl        = dl;
    c.actag     = tag;
    c.pasid     = {8'h5a, tag};
    return c;
  endfunction

  // --------------------------------------
  // output monitor
  // --------------------------------------
  always @(posedge clock_tlx)
  begin
    if (resetn && afu_tlx_cmd_valid)
    begin
      n_issued++;
      if (expect_int)
        compare_value("channel after interrupt", 4'h3, afu_tlx_cmd.afutag[15:12]);
      expect_int = 1'b0;
      case (afu_tlx_cmd.afutag[15:12])
        4'h1:
          if (wr_q.size() == 0)
          begin
            errors++;
            $display("%s: write command issued that was never pushed", cur_test);
          end
          else
          begin
            exp_wr = wr_q.pop_front();
            compare_value("write command", exp_wr, afu_tlx_cmd);
            beat_q.push_back(even_q.pop_front());
            if (exp_wr.dl[1])
              beat_q.push_back(odd_q[0]);
            void'(odd_q.pop_front());
          end
        4'h2:
          if (rd_q.size() == 0)
          begin
            errors++;
            $display("%s: read command issued that was never pushed", cur_test);
          end
          else
            compare_value("read command", rd_q.pop_front(), afu_tlx_cmd);
        default:
          if (int_q.size() == 0)
          begin
            errors++;
            $display("%s: unexpected command on the TLX port", cur_test);
          end
          else
            compare_value("interrupt command", int_q.pop_front(), afu_tlx_cmd);
      endcase
    end
    if (resetn && afu_tlx_cdata_valid)
    begin
      n_beats++;
      if (beat_q.size() == 0)
      begin
        errors++;
        $display("%s: data beat with no write pending", cur_test);
      end
      else
        compare_value("data beat", beat_q.pop_front(), afu_tlx_cdata_bus);
    end
  end

  task automatic apply_reset(input logic [63:0] cmd_cr, input logic [63:0] data_cr);
    @(negedge clock_tlx);
    init_cmd_credit  = cmd_cr[3:0];
    init_data_credit = data_cr[5:0];
    resetn = 1'b0;
    repeat (8) @(negedge clock_tlx);
    resetn = 1'b1;
    n_issued  = 0;
    n_beats   = 0;
    exp_beats = 0;
    compare_value("bdf", {8'h12, 5'h03, 3'h5}, afu_tlx_cmd_bdf);
  endtask

  task automatic return_credits(input int n_cmd, input int n_data);
    int c;
    int d;
    c = n_cmd;
    d = n_data;
    while (c > 0 || d > 0)
    begin
      @(negedge clock_tlx);
      tlx_afu_cmd_credit      = (c > 0);
      tlx_afu_cmd_data_credit = (d > 0);
      if (c > 0)
        c--;
      if (d > 0)
        d--;
      @(negedge clock_tlx);
      tlx_afu_cmd_credit      = 1'b0;
      tlx_afu_cmd_data_credit = 1'b0;
      repeat ($urandom_range(3, 0)) @(negedge clock_tlx);
    end
  endtask

  // issue count must reach n and then stay there
  task automatic wait_issued(input int n);
    int t;
    t = 0;
    while (n_issued < n && t < LIMIT)
    begin
      @(negedge clock_tlx);
      t++;
    end
    repeat (10) @(negedge clock_tlx);
    compare_value("issued count", n, n_issued);
  endtask

  task automatic finish_test();
    int t;
    t = 0;
    while ((wr_q.size() + rd_q.size() + int_q.size() + beat_q.size() > 0) && t < LIMIT)
    begin
      @(negedge clock_tlx);
      t++;
    end
    if (t >= LIMIT)
    begin
      errors++;
      $display("%s: commands or data beats never came out of the DUT", cur_test);
    end
    compare_value("beat count", exp_beats, n_beats);
  endtask

  initial
  begin
    int wd;
    wait (loaded);
    wd = records.size() * LIMIT;
    repeat (wd) @(posedge clock_tlx);
    $display("watchdog: run did not finish within %0d cycles", wd);
    $display("*** FAILED ***");
    $finish;
  end

  initial
  begin
    int fd;
    int rc;
    int test_err;
    string line;
    string tag;
    string name;
    logic [63:0] f1;
    logic [63:0] f2;
    logic [63:0] f3;
    logic [63:0] f4;
    logic [63:0] f5;
    logic [63:0] f6;
    resetn = 1'b0;
    wr_cmd_valid = 1'b0;
    rd_cmd_valid = 1'b0;
    in_cmd_valid = 1'b0;
    tlx_afu_cmd_credit = 1'b0;
    tlx_afu_cmd_data_credit = 1'b0;
    init_cmd_credit = '0;
    init_data_credit = '0;
    wr_cdata = '0;
    wr_cmd = '0;
    rd_cmd = '0;
    in_cmd = '0;
    cur_test = "";
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    test_err = 0;
    expect_int = 1'b0;
    rc = $urandom(26147);
    fd = $fopen("sim/cmd_stimulus.txt", "r");
    if (fd == 0)
      $display("stimulus file sim/cmd_stimulus.txt could not be opened");
    else
    begin
      while (!$feof(fd))
      begin
        rc = $fgets(line, fd);
        if (rc > 1 && line[0] != 8'h23 && line[0] != 8'h0a)
          records.push_back(line);
      end
      $fclose(fd);
    end
    if (records.size() == 0)
      errors++;
    loaded = 1'b1;
    foreach (records[i])
    begin
      f1 = '0;
      f2 = '0;
      f3 = '0;
      f4 = '0;
      f5 = '0;
      f6 = '0;
      rc = $sscanf(records[i], "%s %s %h %h %h %h %h %h", tag, name, f1, f2, f3, f4, f5, f6);
      if (name != cur_test)
      begin
        if (cur_test != "")
        begin
          finish_test();
          tests_run++;
          if (errors != test_err)
            tests_failed++;
          $display("test %s: %0d errors", cur_test, errors - test_err);
        end
        cur_test = name;
        test_err = errors;
      end
      case (tag)
        "INIT": apply_reset(f1, f2);
        "WR":
        begin
          @(negedge clock_tlx);
          wr_cmd = make_cmd(f1[7:0], 4'h1, f2[11:0], f3[1:0], f4);
          wr_cdata = {f6[31:0], f5[31:0]};
          wr_cmd_valid = 1'b1;
          wr_q.push_back(wr_cmd);
          even_q.push_back(f5[31:0]);
          odd_q.push_back(f6[31:0]);
          exp_beats += f3[1] ? 2 : 1;
          @(negedge clock_tlx);
          wr_cmd_valid = 1'b0;
        end
        "RD":
        begin
          @(negedge clock_tlx);
          rd_cmd = make_cmd(f1[7:0], 4'h2, f2[11:0], 2'b00, f3);
          rd_cmd_valid = 1'b1;
          rd_q.push_back(rd_cmd);
          @(negedge clock_tlx);
          rd_cmd_valid = 1'b0;
        end
        "INT":
        begin
          @(negedge clock_tlx);
          in_cmd = make_cmd(8'h58, 4'h3, f1[11:0], 2'b00, f2);
          in_cmd_valid = 1'b1;
          int_q.push_back(in_cmd);
          expect_int = 1'b1;
          @(negedge clock_tlx);
          in_cmd_valid = 1'b0;
        end
        "CRED":
        begin
          wait_issued(int'(f3));
          return_credits(int'(f1), int'(f2));
        end
        "OVF":
        begin
          for (int k = 0; k < int'(f1); k++)
          begin
            @(negedge clock_tlx);
            compare_value("wr_cmd_ready", k < DEPTH / 2, wr_cmd_ready);
            wr_cmd = make_cmd(8'h20, 4'h1, k[11:0], 2'b01, 64'h0);
            wr_cdata = {~k, k};
            wr_cmd_valid = 1'b1;
          end
          @(negedge clock_tlx);
          wr_cmd_valid = 1'b0;
          @(negedge clock_tlx);
          compare_value("fir_fifo_overflow", f2[3:0], fir_fifo_overflow);
          compare_value("rd_cmd_ready", 1'b1, rd_cmd_ready);
        end
        default:
        begin
          errors++;
          $display("unknown record tag %s in test %s", tag, name);
        end
      endcase
    end
    if (cur_test != "")
    begin
      finish_test();
      tests_run++;
      if (errors != test_err)
        tests_failed++;
      $display("test %s: %0d errors", cur_test, errors - test_err);
    end
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

/* vlog.f */
src/tlx_cmd_pkg.sv
src/cmd_fifo.sv
src/credit_tracker.sv
src/wdata_sequencer.sv
src/cmd_arbiter.sv
src/tlx_cmd_converter.sv
sim/tlx_cmd_asserts.sv
sim/tb_tlx_cmd_converter.sv

/* run.sh */
#!/bin/sh
# build and run the TLX command converter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_tlx_cmd_converter -f vlog.f -o tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

/* sim/cmd_stimulus.txt */
# tag test fields in hex: INIT cmd_credit data_credit | WR opcode afutag dl ea even odd
# RD opcode afutag ea | INT afutag ea | CRED cmd_ret data_ret issued_before | OVF pushes ovf
INIT order       f 3f
WR   order       20 001 1 1000 a0000001 b0000001
WR   order       24 002 2 1040 a0000002 b0000002
RD   order       10 001 2000
WR   order       30 003 2 1080 a0000003 b0000003
RD   order       10 002 2040
RD   order       10 003 2080
WR   order       20 004 1 10c0 a0000004 b0000004
INIT cmd_credit  5 3f
WR   cmd_credit  20 011 1 3000 c0000011 d0000011
RD   cmd_credit  10 011 4000
WR   cmd_credit  20 012 2 3040 c0000012 d0000012
RD   cmd_credit  10 012 4040
CRED cmd_credit  1 0 2
CRED cmd_credit  1 0 3
CRED cmd_credit  0 0 4
INIT data_credit f 6
WR   data_credit 24 021 2 5000 e0000021 f0000021
WR   data_credit 24 022 2 5040 e0000022 f0000022
CRED data_credit 0 2 1
CRED data_credit 0 0 2
INIT interrupt   3 3f
WR   interrupt   20 031 1 6000 90000031 80000031
RD   interrupt   10 031 7000
WR   interrupt   20 032 2 6040 90000032 80000032
RD   interrupt   10 032 7040
INT  interrupt   033 8000
CRED interrupt   1 0 0
CRED interrupt   4 0 1
CRED interrupt   0 0 5
INIT overflow    0 0
OVF  overflow    11 7
